//--- llc_bram.sv
`timescale 1ns/100ps

module llc_bram #(
    parameter int width = 32,
    parameter int depth_bits = 6
) (
    input  logic                  clk,
    input  logic [depth_bits-1:0] a0,
    input  logic [depth_bits-1:0] a1,
    input  logic [width-1:0]      d0,
    input  logic [width-1:0]      d1,
    input  logic                  we0,
    input  logic                  we1,
    input  logic                  ce0,
    input  logic                  ce1,
    output logic [width-1:0]      q0,
    output logic [width-1:0]      q1
);

    logic [width-1:0] mem [2**depth_bits];

    // read-first on both ports, port 1 wins a write collision
    always_ff @(posedge clk) begin
        if (ce0) begin
            q0 <= mem[a0];
        end
        if (ce1) begin
            q1 <= mem[a1];
        end
        if (we0) begin
            mem[a0] <= d0;
        end
        if (we1) begin
            mem[a1] <= d1;
        end
    end

endmodule

//--- llc_localmem.sv
`timescale 1ns/100ps

module llc_localmem
    import llc_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_en,
    input  llc_set_t            set_in,
    input  llc_set_t            wr_set,
    input  llc_way_t            way,
    input  logic                wr_en,
    input  line_t               wr_data_line,
    input  llc_tag_t            wr_data_tag,
    input  llc_state_t          wr_data_state,
    input  logic                wr_data_dirty_bit,
    input  logic                wr_en_evict_way,
    input  llc_way_t            wr_data_evict_way,
    input  logic [num_ways-1:0] wr_rst_flush,
    output line_t               rd_data_line [num_ways],
    output llc_tag_t            rd_data_tag [num_ways],
    output llc_state_t          rd_data_state [num_ways],
    output logic                rd_data_dirty_bit [num_ways],
    output llc_way_t            rd_data_evict_way
);

    line_t      line_q [num_ways][num_banks];
    llc_tag_t   tag_q [num_ways][num_banks];
    llc_state_t state_q [num_ways][num_banks];
    logic       dirty_q [num_ways][num_banks];

    logic way_wr [num_ways];
    logic meta_wr [num_ways];
    logic bank_wr [num_banks];
    logic [bank_bits-1:0] rd_bank_q;

    llc_bram_addr_t rd_addr [2];
    llc_bram_addr_t wr_addr [2];

    // even ways in the lower half of the address space, odd ways in the upper
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rd_addr[p] = {p[0], set_in[inbank_bits-1:0]};
            wr_addr[p] = {p[0], wr_set[inbank_bits-1:0]};
        end
    end

    // tag and line follow the addressed way, state and dirty also take the flush
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_wr[w] = wr_en && (way == llc_way_t'(w));
            meta_wr[w] = way_wr[w] || wr_rst_flush[w];
        end
        for (int b = 0; b < num_banks; b++) begin
            bank_wr[b] = (wr_set[set_bits-1 -: bank_bits] == bank_bits'(b));
        end
    end

    // port 0 reads the request set, port 1 commits the update stage's write
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        for (genvar b = 0; b < num_banks; b++) begin : g_bank
            llc_bram #(.width(tag_bits), .depth_bits(bram_addr_bits)) tag_bram (
                .clk(clk),
                .a0(rd_addr[w % 2]), .a1(wr_addr[w % 2]),
                .d0('0), .d1(wr_data_tag),
                .we0(1'b0), .we1(way_wr[w] && bank_wr[b]),
                .ce0(rd_en), .ce1(1'b0),
                .q0(tag_q[w][b]), .q1()
            );

            llc_bram #(.width(2), .depth_bits(bram_addr_bits)) state_bram (
                .clk(clk),
                .a0(rd_addr[w % 2]), .a1(wr_addr[w % 2]),
                .d0('0), .d1(wr_data_state),
                .we0(1'b0), .we1(meta_wr[w] && bank_wr[b]),
                .ce0(rd_en), .ce1(1'b0),
                .q0(state_q[w][b]), .q1()
            );

            llc_bram #(.width(1), .depth_bits(bram_addr_bits)) dirty_bram (
                .clk(clk),
                .a0(rd_addr[w % 2]), .a1(wr_addr[w % 2]),
                .d0(1'b0), .d1(wr_data_dirty_bit),
                .we0(1'b0), .we1(meta_wr[w] && bank_wr[b]),
                .ce0(rd_en), .ce1(1'b0),
                .q0(dirty_q[w][b]), .q1()
            );

            for (genvar k = 0; k < slices_per_line; k++) begin : g_slice
                llc_bram #(.width(slice_bits), .depth_bits(bram_addr_bits)) line_bram (
                    .clk(clk),
                    .a0(rd_addr[w % 2]), .a1(wr_addr[w % 2]),
                    .d0('0), .d1(wr_data_line[slice_bits*k +: slice_bits]),
                    .we0(1'b0), .we1(way_wr[w] && bank_wr[b]),
                    .ce0(rd_en), .ce1(1'b0),
                    .q0(line_q[w][b][slice_bits*k +: slice_bits]), .q1()
                );
            end
        end
    end

    // one round-robin pointer per set, indexed by the whole set number
    llc_bram #(.width(way_bits), .depth_bits(set_bits)) evict_way_bram (
        .clk(clk),
        .a0(set_in), .a1(wr_set),
        .d0('0), .d1(wr_data_evict_way),
        .we0(1'b0), .we1(wr_en_evict_way),
        .ce0(rd_en), .ce1(1'b0),
        .q0(rd_data_evict_way), .q1()
    );

    // bank select must line up with the data the rams return
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_bank_q <= set_in[set_bits-1 -: bank_bits];
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            rd_data_line[w] = line_q[w][rd_bank_q];
            rd_data_tag[w] = tag_q[w][rd_bank_q];
            rd_data_state[w] = state_q[w][rd_bank_q];
            rd_data_dirty_bit[w] = dirty_q[w][rd_bank_q];
        end
    end

    a_flush_excludes_write: assert property (
        @(posedge clk) disable iff (rst) !(wr_en && (|wr_rst_flush))
    );

endmodule

//--- llc_lookup.sv
`timescale 1ns/100ps

module llc_lookup
    import llc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  llc_op_t    req_op,
    input  llc_addr_t  req_addr,
    input  line_t      req_line,
    input  line_t      rd_data_line [num_ways],
    input  llc_tag_t   rd_data_tag [num_ways],
    input  llc_state_t rd_data_state [num_ways],
    input  logic       rd_data_dirty_bit [num_ways],
    input  llc_way_t   rd_data_evict_way,
    input  logic       fwd_valid,
    input  llc_set_t   fwd_set,
    input  llc_way_t   fwd_way,
    input  llc_tag_t   fwd_tag,
    input  llc_state_t fwd_state,
    input  logic       fwd_dirty,
    input  line_t      fwd_line,
    input  logic       fwd_flush,
    input  logic       fwd_evict,
    input  llc_way_t   fwd_evict_way,
    input  logic       fwd2_valid,
    input  llc_set_t   fwd2_set,
    input  llc_way_t   fwd2_way,
    input  llc_tag_t   fwd2_tag,
    input  llc_state_t fwd2_state,
    input  logic       fwd2_dirty,
    input  line_t      fwd2_line,
    input  logic       fwd2_flush,
    input  logic       fwd2_evict,
    input  llc_way_t   fwd2_evict_way,
    output logic       lk_valid,
    output llc_op_t    lk_op,
    output llc_addr_t  lk_addr,
    output line_t      lk_line,
    output logic       lk_hit,
    output llc_way_t   lk_way,
    output logic       lk_victim_valid_dirty,
    output llc_tag_t   lk_victim_tag,
    output line_t      lk_victim_line,
    output line_t      lk_hit_line,
    output llc_way_t   lk_evict_way
);

    logic      req_valid_q;
    llc_op_t   req_op_q;
    llc_addr_t req_addr_q;
    line_t     req_line_q;
    llc_set_t  req_set;
    llc_tag_t  req_tag;

    // index 0 is the older write, index 1 the newer
    logic       f_valid [2];
    llc_set_t   f_set [2];
    llc_way_t   f_way [2];
    llc_tag_t   f_tag [2];
    llc_state_t f_state [2];
    logic       f_dirty [2];
    line_t      f_line [2];
    logic       f_flush [2];
    logic       f_evict [2];
    llc_way_t   f_evict_way [2];

    line_t      line_v [num_ways];
    llc_tag_t   tag_v [num_ways];
    llc_state_t state_v [num_ways];
    logic       dirty_v [num_ways];
    llc_way_t   evict_v;

    logic [num_ways-1:0] hit_vec;
    logic     hit;
    llc_way_t hit_way;
    llc_way_t victim;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            req_op_q <= req_op;
            req_addr_q <= req_addr;
            req_line_q <= req_line;
        end
    end

    assign req_set = req_addr_q[set_bits-1:0];
    assign req_tag = req_addr_q[addr_bits-1:set_bits];

    assign f_valid = '{fwd2_valid, fwd_valid};
    assign f_set = '{fwd2_set, fwd_set};
    assign f_way = '{fwd2_way, fwd_way};
    assign f_tag = '{fwd2_tag, fwd_tag};
    assign f_state = '{fwd2_state, fwd_state};
    assign f_dirty = '{fwd2_dirty, fwd_dirty};
    assign f_line = '{fwd2_line, fwd_line};
    assign f_flush = '{fwd2_flush, fwd_flush};
    assign f_evict = '{fwd2_evict, fwd_evict};
    assign f_evict_way = '{fwd2_evict_way, fwd_evict_way};

    // writes not yet visible in the ram read, applied oldest first
    always_comb begin
        evict_v = rd_data_evict_way;
        for (int w = 0; w < num_ways; w++) begin
            line_v[w] = rd_data_line[w];
            tag_v[w] = rd_data_tag[w];
            state_v[w] = rd_data_state[w];
            dirty_v[w] = rd_data_dirty_bit[w];
        end
        for (int r = 0; r < 2; r++) begin
            if (f_valid[r] && f_set[r] == req_set) begin
                for (int w = 0; w < num_ways; w++) begin
                    if (f_flush[r] || f_way[r] == llc_way_t'(w)) begin
                        state_v[w] = f_state[r];
                        dirty_v[w] = f_dirty[r];
                    end
                end
                if (!f_flush[r]) begin
                    tag_v[f_way[r]] = f_tag[r];
                    line_v[f_way[r]] = f_line[r];
                end
                if (f_evict[r]) begin
                    evict_v = f_evict_way[r];
                end
            end
        end
    end

    // downward scan leaves the lowest invalid way as victim
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        victim = evict_v;
        for (int w = num_ways - 1; w >= 0; w--) begin
            hit_vec[w] = (state_v[w] == state_valid) && (tag_v[w] == req_tag);
            if (hit_vec[w]) begin
                hit = 1'b1;
                hit_way = llc_way_t'(w);
            end
            if (state_v[w] != state_valid) begin
                victim = llc_way_t'(w);
            end
        end
    end

    assign lk_valid = req_valid_q;
    assign lk_op = req_op_q;
    assign lk_addr = req_addr_q;
    assign lk_line = req_line_q;
    assign lk_hit = hit;
    assign lk_way = hit ? hit_way : victim;
    assign lk_victim_valid_dirty = (state_v[victim] == state_valid) && dirty_v[victim];
    assign lk_victim_tag = tag_v[victim];
    assign lk_victim_line = line_v[victim];
    assign lk_hit_line = line_v[hit_way];
    assign lk_evict_way = evict_v;

    // a tag is only ever allocated once per set
    a_single_hit: assert property (
        @(posedge clk) disable iff (rst)
        (req_valid_q && req_op_q != op_flush) |-> $onehot0(hit_vec)
    );

endmodule

//--- llc_pkg.sv
package llc_pkg;

    // cache geometry
    localparam int num_ways = 4;
    localparam int way_bits = 2;
    localparam int set_bits = 6;
    localparam int bank_bits = 1;
    localparam int num_banks = 2;
    localparam int inbank_bits = set_bits - bank_bits;
    localparam int bram_addr_bits = 6;
    localparam int tag_bits = 10;
    localparam int addr_bits = tag_bits + set_bits;

    // a line is stored as 32-bit slices
    localparam int slice_bits = 32;
    localparam int slices_per_line = 4;
    localparam int line_bits = slice_bits * slices_per_line;

    typedef logic [set_bits-1:0] llc_set_t;
    typedef logic [tag_bits-1:0] llc_tag_t;
    typedef logic [way_bits-1:0] llc_way_t;
    typedef logic [line_bits-1:0] line_t;
    typedef logic [1:0] llc_state_t;
    typedef logic [1:0] llc_op_t;
    typedef logic [addr_bits-1:0] llc_addr_t;
    typedef logic [bram_addr_bits-1:0] llc_bram_addr_t;

    localparam llc_state_t state_invalid = 2'd0;
    localparam llc_state_t state_valid = 2'd1;

    localparam llc_op_t op_read = 2'd0;
    localparam llc_op_t op_write = 2'd1;
    localparam llc_op_t op_flush = 2'd2;

endpackage

//--- llc_slice_top.sv
`timescale 1ns/100ps

module llc_slice_top
    import llc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  llc_op_t   req_op,
    input  llc_addr_t req_addr,
    input  line_t     req_line,
    output logic      rsp_valid,
    output logic      rsp_hit,
    output llc_way_t  rsp_way,
    output line_t     rsp_line,
    output logic      wb_valid,
    output llc_addr_t wb_addr,
    output line_t     wb_line
);

    line_t      rd_data_line [num_ways];
    llc_tag_t   rd_data_tag [num_ways];
    llc_state_t rd_data_state [num_ways];
    logic       rd_data_dirty_bit [num_ways];
    llc_way_t   rd_data_evict_way;

    llc_set_t   wr_set;
    llc_way_t   way;
    logic       wr_en;
    line_t      wr_data_line;
    llc_tag_t   wr_data_tag;
    llc_state_t wr_data_state;
    logic       wr_data_dirty_bit;
    logic       wr_en_evict_way;
    llc_way_t   wr_data_evict_way;
    logic [num_ways-1:0] wr_rst_flush;

    logic lk_valid, lk_hit, lk_victim_valid_dirty;
    llc_op_t lk_op;
    llc_addr_t lk_addr;
    line_t lk_line, lk_victim_line, lk_hit_line;
    llc_way_t lk_way, lk_evict_way;
    llc_tag_t lk_victim_tag;

    logic fwd_valid, fwd_dirty, fwd_flush, fwd_evict;
    logic fwd2_valid, fwd2_dirty, fwd2_flush, fwd2_evict;
    llc_set_t fwd_set, fwd2_set;
    llc_way_t fwd_way, fwd2_way, fwd_evict_way, fwd2_evict_way;
    llc_tag_t fwd_tag, fwd2_tag;
    llc_state_t fwd_state, fwd2_state;
    line_t fwd_line, fwd2_line;

    llc_localmem llc_localmem_i (
        .clk(clk), .rst(rst),
        .rd_en(req_valid), .set_in(req_addr[set_bits-1:0]),
        .wr_set(wr_set), .way(way), .wr_en(wr_en),
        .wr_data_line(wr_data_line), .wr_data_tag(wr_data_tag),
        .wr_data_state(wr_data_state), .wr_data_dirty_bit(wr_data_dirty_bit),
        .wr_en_evict_way(wr_en_evict_way), .wr_data_evict_way(wr_data_evict_way),
        .wr_rst_flush(wr_rst_flush),
        .rd_data_line(rd_data_line), .rd_data_tag(rd_data_tag),
        .rd_data_state(rd_data_state), .rd_data_dirty_bit(rd_data_dirty_bit),
        .rd_data_evict_way(rd_data_evict_way)
    );

    llc_lookup llc_lookup_i (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr), .req_line(req_line),
        .rd_data_line(rd_data_line), .rd_data_tag(rd_data_tag),
        .rd_data_state(rd_data_state), .rd_data_dirty_bit(rd_data_dirty_bit),
        .rd_data_evict_way(rd_data_evict_way),
        .fwd_valid(fwd_valid), .fwd_set(fwd_set), .fwd_way(fwd_way), .fwd_tag(fwd_tag),
        .fwd_state(fwd_state), .fwd_dirty(fwd_dirty), .fwd_line(fwd_line),
        .fwd_flush(fwd_flush), .fwd_evict(fwd_evict), .fwd_evict_way(fwd_evict_way),
        .fwd2_valid(fwd2_valid), .fwd2_set(fwd2_set), .fwd2_way(fwd2_way),
        .fwd2_tag(fwd2_tag), .fwd2_state(fwd2_state), .fwd2_dirty(fwd2_dirty),
        .fwd2_line(fwd2_line), .fwd2_flush(fwd2_flush), .fwd2_evict(fwd2_evict),
        .fwd2_evict_way(fwd2_evict_way),
        .lk_valid(lk_valid), .lk_op(lk_op), .lk_addr(lk_addr), .lk_line(lk_line),
        .lk_hit(lk_hit), .lk_way(lk_way), .lk_victim_valid_dirty(lk_victim_valid_dirty),
        .lk_victim_tag(lk_victim_tag), .lk_victim_line(lk_victim_line),
        .lk_hit_line(lk_hit_line), .lk_evict_way(lk_evict_way)
    );

    llc_update llc_update_i (
        .clk(clk), .rst(rst),
        .lk_valid(lk_valid), .lk_op(lk_op), .lk_addr(lk_addr), .lk_line(lk_line),
        .lk_hit(lk_hit), .lk_way(lk_way), .lk_victim_valid_dirty(lk_victim_valid_dirty),
        .lk_victim_tag(lk_victim_tag), .lk_victim_line(lk_victim_line),
        .lk_hit_line(lk_hit_line), .lk_evict_way(lk_evict_way),
        .wr_set(wr_set), .way(way), .wr_en(wr_en),
        .wr_data_line(wr_data_line), .wr_data_tag(wr_data_tag),
        .wr_data_state(wr_data_state), .wr_data_dirty_bit(wr_data_dirty_bit),
        .wr_en_evict_way(wr_en_evict_way), .wr_data_evict_way(wr_data_evict_way),
        .wr_rst_flush(wr_rst_flush),
        .fwd_valid(fwd_valid), .fwd_set(fwd_set), .fwd_way(fwd_way), .fwd_tag(fwd_tag),
        .fwd_state(fwd_state), .fwd_dirty(fwd_dirty), .fwd_line(fwd_line),
        .fwd_flush(fwd_flush), .fwd_evict(fwd_evict), .fwd_evict_way(fwd_evict_way),
        .fwd2_valid(fwd2_valid), .fwd2_set(fwd2_set), .fwd2_way(fwd2_way),
        .fwd2_tag(fwd2_tag), .fwd2_state(fwd2_state), .fwd2_dirty(fwd2_dirty),
        .fwd2_line(fwd2_line), .fwd2_flush(fwd2_flush), .fwd2_evict(fwd2_evict),
        .fwd2_evict_way(fwd2_evict_way),
        .rsp_valid(rsp_valid), .rsp_hit(rsp_hit), .rsp_way(rsp_way), .rsp_line(rsp_line),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_line(wb_line)
    );

endmodule

//--- llc_tb.sv
`timescale 1ns/100ps

module llc_tb
    import llc_pkg::*;
();

    localparam int num_sets = 2**set_bits;
    localparam int stream_len = 300;
    // requests issued over the whole run, flush of all sets first
    localparam int planned_reqs = num_sets + 16 + 8 + 8 + 5 + 16 + stream_len;
    localparam int watchdog_ns = planned_reqs * 40 + 16 * 20 + 2000;

    typedef struct packed {
        int        due;
        logic      hit;
        logic      check_way;
        llc_way_t  way;
        line_t     line;
        logic      wb;
        llc_addr_t wb_addr;
        line_t     wb_line;
    } expect_t;

    logic      clk;
    logic      rst;
    logic      req_valid;
    llc_op_t   req_op;
    llc_addr_t req_addr;
    line_t     req_line;
    logic      rsp_valid;
    logic      rsp_hit;
    llc_way_t  rsp_way;
    line_t     rsp_line;
    logic      wb_valid;
    llc_addr_t wb_addr;
    line_t     wb_line;

    int          cyc;
    logic [31:0] rng;
    expect_t     exp_q [$];
    expect_t     mon_e;

    // reference state per set and way
    logic     m_valid [num_sets][num_ways];
    logic     m_dirty [num_sets][num_ways];
    llc_tag_t m_tag [num_sets][num_ways];
    line_t    m_line [num_sets][num_ways];
    llc_way_t m_rr [num_sets];

    llc_slice_top llc_slice_top_i (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr), .req_line(req_line),
        .rsp_valid(rsp_valid), .rsp_hit(rsp_hit), .rsp_way(rsp_way), .rsp_line(rsp_line),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_line(wb_line)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bool(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_way(input string name, input llc_way_t got, input llc_way_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input llc_addr_t got, input llc_addr_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int k = 0; k < slices_per_line; k++) begin
            l[slice_bits*k +: slice_bits] = rand32();
        end
        return l;
    endfunction

    // expected response of one request, then the state change it causes
    task automatic model_apply(input llc_op_t op, input llc_addr_t addr, input line_t line,
                               output expect_t e);
        llc_set_t s;
        llc_tag_t t;
        llc_way_t v;
        int hw;
        s = addr[set_bits-1:0];
        t = addr[addr_bits-1:set_bits];
        hw = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                hw = w;
            end
        end
        // lowest invalid way, else the round-robin pointer
        v = m_rr[s];
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!m_valid[s][w]) begin
                v = llc_way_t'(w);
            end
        end
        e = '0;
        e.hit = (op != op_flush) && (hw >= 0);
        e.check_way = (op != op_flush);
        e.way = e.hit ? llc_way_t'(hw) : v;
        e.line = (op == op_read && e.hit) ? m_line[s][hw] : '0;
        e.wb = (op == op_write) && !e.hit && m_valid[s][v] && m_dirty[s][v];
        e.wb_addr = {m_tag[s][v], s};
        e.wb_line = m_line[s][v];
        if (op == op_write) begin
            if (!e.hit && v == m_rr[s]) begin
                m_rr[s] = v + 1'b1;
            end
            m_valid[s][e.way] = 1'b1;
            m_dirty[s][e.way] = 1'b1;
            m_tag[s][e.way] = t;
            m_line[s][e.way] = line;
        end else if (op == op_flush) begin
            for (int w = 0; w < num_ways; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
            m_rr[s] = '0;
        end
    endtask

    task automatic issue(input llc_op_t op, input llc_addr_t addr, input line_t line);
        expect_t e;
        @(posedge clk);
        model_apply(op, addr, line, e);
        // sampled one edge later, response valid after the edge after that
        e.due = cyc + 3;
        exp_q.push_back(e);
        req_valid <= 1'b1;
        req_op <= op;
        req_addr <= addr;
        req_line <= line;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    task automatic finish_requests();
        idle(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // responses checked on the falling edge, one slot per cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                mon_e = exp_q.pop_front();
                check_bool("rsp_valid", rsp_valid, 1'b1);
                check_bool("rsp_hit", rsp_hit, mon_e.hit);
                if (mon_e.check_way) begin
                    check_way("rsp_way", rsp_way, mon_e.way);
                end
                check_line("rsp_line", rsp_line, mon_e.line);
                check_bool("wb_valid", wb_valid, mon_e.wb);
                if (mon_e.wb) begin
                    check_addr("wb_addr", wb_addr, mon_e.wb_addr);
                    check_line("wb_line", wb_line, mon_e.wb_line);
                end
            end else begin
                check_bool("rsp_valid", rsp_valid, 1'b0);
                check_bool("wb_valid", wb_valid, 1'b0);
            end
        end
    end

    task automatic flush_all_sets();
        for (int s = 0; s < num_sets; s++) begin
            issue(op_flush, {10'd0, llc_set_t'(s)}, '0);
        end
        finish_requests();
    endtask

    task automatic read_miss_after_flush();
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = rand32();
            issue(op_read, r[15:0], '0);
        end
        finish_requests();
    endtask

    task automatic write_then_read();
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r = rand32();
            issue(op_write, r[15:0], rand_line());
            idle(3);
            issue(op_read, r[15:0], '0);
        end
        finish_requests();
    endtask

    task automatic evict_in_order();
        llc_set_t s;
        s = 6'd5;
        issue(op_flush, {10'h000, s}, '0);
        idle(1);
        // fifth write replaces way 0, the sixth way 1
        for (int i = 0; i < 6; i++) begin
            issue(op_write, {llc_tag_t'(10'h100 + i), s}, rand_line());
            idle(1);
        end
        issue(op_read, {10'h100, s}, '0);
        finish_requests();
    endtask

    task automatic flush_keeps_other_sets();
        issue(op_write, {10'h0a5, 6'd10}, rand_line());
        issue(op_write, {10'h0b6, 6'd11}, rand_line());
        idle(2);
        issue(op_flush, {10'h000, 6'd10}, '0);
        idle(2);
        issue(op_read, {10'h0a5, 6'd10}, '0);
        issue(op_read, {10'h0b6, 6'd11}, '0);
        finish_requests();
    endtask

    task automatic same_set_back_to_back();
        llc_set_t s;
        s = 6'd20;
        issue(op_flush, {10'h000, s}, '0);
        issue(op_write, {10'h011, s}, rand_line());
        issue(op_read, {10'h011, s}, '0);
        issue(op_write, {10'h012, s}, rand_line());
        issue(op_write, {10'h013, s}, rand_line());
        issue(op_read, {10'h012, s}, '0);
        issue(op_read, {10'h013, s}, '0);
        issue(op_write, {10'h011, s}, rand_line());
        issue(op_flush, {10'h000, s}, '0);
        issue(op_read, {10'h011, s}, '0);
        issue(op_read, {10'h013, s}, '0);
        // pointer updates follow each other every cycle
        for (int i = 0; i < 5; i++) begin
            issue(op_write, {llc_tag_t'(10'h021 + i), s}, rand_line());
        end
        finish_requests();
    endtask

    task automatic random_stream();
        logic [31:0] r;
        for (int i = 0; i < stream_len; i++) begin
            r = rand32();
            // sets 0, 1, 32 and 33, eight tags each
            if (r[0]) begin
                issue(op_write, {7'd0, r[5:3], r[2], 4'd0, r[1]}, rand_line());
            end else begin
                issue(op_read, {7'd0, r[5:3], r[2], 4'd0, r[1]}, '0);
            end
        end
        finish_requests();
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: requests did not complete within %0d ns", watchdog_ns);
        stop_run();
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_op = op_read;
        req_addr = '0;
        req_line = '0;
        cyc = 0;
        rng = 32'd16459;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        flush_all_sets();
        read_miss_after_flush();
        write_then_read();
        evict_in_order();
        flush_keeps_other_sets();
        same_set_back_to_back();
        random_stream();
        $display("No errors");
        $finish;
    end

endmodule

//--- llc_update.sv
`timescale 1ns/100ps

module llc_update
    import llc_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                lk_valid,
    input  llc_op_t             lk_op,
    input  llc_addr_t           lk_addr,
    input  line_t               lk_line,
    input  logic                lk_hit,
    input  llc_way_t            lk_way,
    input  logic                lk_victim_valid_dirty,
    input  llc_tag_t            lk_victim_tag,
    input  line_t               lk_victim_line,
    input  line_t               lk_hit_line,
    input  llc_way_t            lk_evict_way,
    output llc_set_t            wr_set,
    output llc_way_t            way,
    output logic                wr_en,
    output line_t               wr_data_line,
    output llc_tag_t            wr_data_tag,
    output llc_state_t          wr_data_state,
    output logic                wr_data_dirty_bit,
    output logic                wr_en_evict_way,
    output llc_way_t            wr_data_evict_way,
    output logic [num_ways-1:0] wr_rst_flush,
    output logic                fwd_valid,
    output llc_set_t            fwd_set,
    output llc_way_t            fwd_way,
    output llc_tag_t            fwd_tag,
    output llc_state_t          fwd_state,
    output logic                fwd_dirty,
    output line_t               fwd_line,
    output logic                fwd_flush,
    output logic                fwd_evict,
    output llc_way_t            fwd_evict_way,
    output logic                fwd2_valid,
    output llc_set_t            fwd2_set,
    output llc_way_t            fwd2_way,
    output llc_tag_t            fwd2_tag,
    output llc_state_t          fwd2_state,
    output logic                fwd2_dirty,
    output line_t               fwd2_line,
    output logic                fwd2_flush,
    output logic                fwd2_evict,
    output llc_way_t            fwd2_evict_way,
    output logic                rsp_valid,
    output logic                rsp_hit,
    output llc_way_t            rsp_way,
    output line_t               rsp_line,
    output logic                wb_valid,
    output llc_addr_t           wb_addr,
    output line_t               wb_line
);

    logic      u_valid;
    llc_op_t   u_op;
    llc_addr_t u_addr;
    line_t     u_line;
    logic      u_hit;
    llc_way_t  u_way;
    logic      u_victim_vd;
    llc_tag_t  u_victim_tag;
    line_t     u_victim_line;
    line_t     u_hit_line;
    llc_way_t  u_evict_way;
    logic      is_write;
    logic      is_flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            u_valid <= 1'b0;
            fwd2_valid <= 1'b0;
        end else begin
            u_valid <= lk_valid;
            fwd2_valid <= fwd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (lk_valid) begin
            u_op <= lk_op;
            u_addr <= lk_addr;
            u_line <= lk_line;
            u_hit <= lk_hit;
            u_way <= lk_way;
            u_victim_vd <= lk_victim_valid_dirty;
            u_victim_tag <= lk_victim_tag;
            u_victim_line <= lk_victim_line;
            u_hit_line <= lk_hit_line;
            u_evict_way <= lk_evict_way;
        end
    end

    assign is_write = u_valid && (u_op == op_write);
    assign is_flush = u_valid && (u_op == op_flush);

    // commits at the next edge
    assign wr_set = u_addr[set_bits-1:0];
    assign way = u_way;
    assign wr_en = is_write;
    assign wr_data_line = u_line;
    assign wr_data_tag = u_addr[addr_bits-1:set_bits];
    assign wr_data_state = is_write ? state_valid : state_invalid;
    assign wr_data_dirty_bit = is_write;
    assign wr_rst_flush = {num_ways{is_flush}};

    // pointer moves past the way it just replaced, a flush restarts it at way 0
    assign wr_en_evict_way = is_flush || (is_write && !u_hit && u_way == u_evict_way);
    assign wr_data_evict_way = is_flush ? '0 : llc_way_t'(u_way + 1'b1);

    assign fwd_valid = is_write || is_flush;
    assign fwd_set = wr_set;
    assign fwd_way = way;
    assign fwd_tag = wr_data_tag;
    assign fwd_state = wr_data_state;
    assign fwd_dirty = wr_data_dirty_bit;
    assign fwd_line = wr_data_line;
    assign fwd_flush = is_flush;
    assign fwd_evict = wr_en_evict_way;
    assign fwd_evict_way = wr_data_evict_way;

    // the ram is read-first, so the last write stays visible one more cycle
    always_ff @(posedge clk) begin
        fwd2_set <= fwd_set;
        fwd2_way <= fwd_way;
        fwd2_tag <= fwd_tag;
        fwd2_state <= fwd_state;
        fwd2_dirty <= fwd_dirty;
        fwd2_line <= fwd_line;
        fwd2_flush <= fwd_flush;
        fwd2_evict <= fwd_evict;
        fwd2_evict_way <= fwd_evict_way;
    end

    assign rsp_valid = u_valid;
    assign rsp_hit = u_hit && (u_op != op_flush);
    assign rsp_way = u_way;
    assign rsp_line = (u_op == op_read && u_hit) ? u_hit_line : '0;

    assign wb_valid = is_write && !u_hit && u_victim_vd;
    assign wb_addr = {u_victim_tag, wr_set};
    assign wb_line = u_victim_line;

    // an evicted line never carries the tag being allocated
    a_wb_on_miss: assert property (
        @(posedge clk) disable iff (rst) wb_valid |-> (rsp_valid && wb_addr != u_addr)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module llc_tb -f sim.f
# the log decides the result, not the exit code of the run
./obj_dir/Vllc_tb > sim.log 2>&1 || true
cat sim.log
if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- sim.f
llc_pkg.sv
llc_bram.sv
llc_localmem.sv
llc_lookup.sv
llc_update.sv
llc_slice_top.sv
llc_tb.sv
